// File: Bender.yml
package:
  name: axis_lrelu_engine

sources:
  - src/lrelu_pkg.sv
  - src/lrelu_config_ctrl.sv
  - src/lrelu_dw_bank.sv
  - src/lrelu_engine.sv
  - src/axis_reg_slice_lrelu.sv
  - src/axis_lrelu_engine.sv
  - target: test
    files:
      - tb/tb_axis_lrelu_engine.sv

// File: sources.f
src/lrelu_pkg.sv
src/lrelu_config_ctrl.sv
src/lrelu_dw_bank.sv
src/lrelu_engine.sv
src/axis_reg_slice_lrelu.sv
src/axis_lrelu_engine.sv
tb/tb_axis_lrelu_engine.sv

// File: src/axis_lrelu_engine.sv
module axis_lrelu_engine (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               s_axis_tvalid,
    output logic                               s_axis_tready,
    input  logic [lrelu_pkg::S_DATA_WIDTH-1:0] s_axis_tdata,   // Config or MEMBERS x UNITS words
    input  logic                               s_axis_tlast,
    output logic                               m_axis_tvalid,
    input  logic                               m_axis_tready,
    output logic [lrelu_pkg::M_DATA_WIDTH-1:0] m_axis_tdata,   // UNITS x 8 bit
    output logic                               m_axis_tlast
);
    import lrelu_pkg::*;

    logic                    dw_s_valid;
    logic                    dw_s_ready;
    logic                    e_valid;     // Converter to engine
    logic [E_DATA_WIDTH-1:0] e_data;
    logic                    e_last;
    logic                    p_valid;     // Engine to slice
    logic [M_DATA_WIDTH-1:0] p_data;
    logic                    p_last;
    logic                    clken;       // Slice ready, stalls engine and converter
    logic                    scale_we;
    logic                    bias_we;
    logic                    commit;

    lrelu_config_ctrl ctrl (
        .aclk          (aclk         ),
        .reset         (reset        ),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast ),
        .s_axis_tready (s_axis_tready),
        .dw_s_valid    (dw_s_valid   ),
        .dw_s_ready    (dw_s_ready   ),
        .e_valid       (e_valid      ),
        .e_last        (e_last       ),
        .clken         (clken        ),
        .scale_we      (scale_we     ),
        .bias_we       (bias_we      ),
        .commit        (commit       )
    );

    lrelu_dw_bank dw_bank (
        .aclk    (aclk        ),
        .reset   (reset       ),
        .s_valid (dw_s_valid  ),
        .s_ready (dw_s_ready  ),
        .s_data  (s_axis_tdata),
        .s_last  (s_axis_tlast),
        .m_valid (e_valid     ),
        .m_ready (clken       ),
        .m_data  (e_data      ),
        .m_last  (e_last      )
    );

    lrelu_engine engine (
        .aclk        (aclk        ),
        .reset       (reset       ),
        .clken       (clken       ),
        .s_valid     (e_valid     ),
        .s_data      (e_data      ),
        .s_last      (e_last      ),
        .m_valid     (p_valid     ),
        .m_data      (p_data      ),
        .m_last      (p_last      ),
        .scale_we    (scale_we    ),
        .bias_we     (bias_we     ),
        .config_data (s_axis_tdata),  // Full width config beat
        .commit      (commit      )
    );

    axis_reg_slice_lrelu slice (
        .aclk    (aclk         ),
        .reset   (reset        ),
        .s_valid (p_valid      ),
        .s_ready (clken        ),
        .s_data  (p_data       ),
        .s_last  (p_last       ),
        .m_valid (m_axis_tvalid),
        .m_ready (m_axis_tready),
        .m_data  (m_axis_tdata ),
        .m_last  (m_axis_tlast )
    );

endmodule

// File: src/axis_reg_slice_lrelu.sv
module axis_reg_slice_lrelu (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               s_valid,
    output logic                               s_ready,    // Registered
    input  logic [lrelu_pkg::M_DATA_WIDTH-1:0] s_data,
    input  logic                               s_last,
    output logic                               m_valid,
    input  logic                               m_ready,
    output logic [lrelu_pkg::M_DATA_WIDTH-1:0] m_data,
    output logic                               m_last
);
    import lrelu_pkg::*;

    logic [M_DATA_WIDTH-1:0] skid_data_q;
    logic                    skid_last_q;
    logic                    skid_valid_q;
    logic                    m_valid_q;
    logic                    s_ready_q;
    logic                    s_hs;
    logic                    load_main;   // Input straight into main
    logic                    load_skid;   // Input parked while main stalls
    logic                    unload_skid; // Skid moves up into main

    assign s_hs        = s_valid && s_ready_q;
    assign load_skid   = s_hs && m_valid_q && !m_ready;
    assign load_main   = s_hs && !load_skid;
    assign unload_skid = skid_valid_q && m_ready;

    assign s_ready = s_ready_q;
    assign m_valid = m_valid_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid_q    <= 1'b0;
            skid_valid_q <= 1'b0;
            s_ready_q    <= 1'b0;
        end else begin
            if (unload_skid)
                skid_valid_q <= 1'b0;           // Main stays valid with skid word
            else if (load_skid)
                skid_valid_q <= 1'b1;
            if (load_main)
                m_valid_q <= 1'b1;
            else if (m_ready && !skid_valid_q)
                m_valid_q <= 1'b0;              // Drained, nothing behind it
            s_ready_q <= skid_valid_q ? m_ready : !load_skid;
        end
    end

    // Payload
    always_ff @(posedge aclk) begin
        if (unload_skid) begin
            m_data <= skid_data_q;
            m_last <= skid_last_q;
        end else if (load_main) begin
            m_data <= s_data;
            m_last <= s_last;
        end
        if (load_skid) begin
            skid_data_q <= s_data;
            skid_last_q <= s_last;
        end
    end

endmodule

// File: src/lrelu_config_ctrl.sv
module lrelu_config_ctrl (
    input  logic aclk,
    input  logic reset,
    input  logic s_axis_tvalid,
    input  logic s_axis_tlast,
    output logic s_axis_tready,
    output logic dw_s_valid,      // Valid towards the width converter
    input  logic dw_s_ready,
    input  logic e_valid,         // Converter output side
    input  logic e_last,
    input  logic clken,           // Engine advance, also config path ready
    output logic scale_we,
    output logic bias_we,
    output logic commit
);
    import lrelu_pkg::*;

    config_state_t state;
    config_state_t state_next;
    logic          s_hs;          // Slave handshake, any state
    logic          s_last_hs;     // Last data beat into converter
    logic          e_last_hs;     // Last member out of converter

    assign s_hs      = s_axis_tvalid && s_axis_tready;
    assign s_last_hs = s_hs && s_axis_tlast;
    assign e_last_hs = e_valid && e_last && clken;

    always_ff @(posedge aclk) begin
        if (reset)
            state <= WRITE_SCALE_S;   // First two beats after reset are config
        else
            state <= state_next;
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            PASS_S: begin
                if (s_last_hs)
                    state_next = DRAIN_S;
            end
            DRAIN_S: begin
                if (e_last_hs)
                    state_next = WRITE_SCALE_S;
            end
            WRITE_SCALE_S: begin
                if (s_hs)
                    state_next = WRITE_BIAS_S;
            end
            WRITE_BIAS_S: begin
                if (s_hs)
                    state_next = COMMIT_S;
            end
            COMMIT_S: begin
                if (clken)                    // Token accepted by engine
                    state_next = PASS_S;
            end
            default: state_next = WRITE_SCALE_S;
        endcase
    end

    // Port steering and strobes
    always_comb begin
        dw_s_valid    = 1'b0;
        s_axis_tready = 1'b0;
        scale_we      = 1'b0;
        bias_we       = 1'b0;
        commit        = 1'b0;
        case (state)
            PASS_S: begin
                dw_s_valid    = s_axis_tvalid;
                s_axis_tready = dw_s_ready;
            end
            WRITE_SCALE_S: begin
                s_axis_tready = clken;
                scale_we      = s_axis_tvalid && clken;   // tlast ignored here
            end
            WRITE_BIAS_S: begin
                s_axis_tready = clken;
                bias_we       = s_axis_tvalid && clken;
            end
            COMMIT_S: begin
                commit = clken;       // One cycle, moves with the pipeline
            end
            default: begin
                // DRAIN_S keeps the slave port blocked
                s_axis_tready = 1'b0;
            end
        endcase
    end

endmodule

// File: src/lrelu_dw_bank.sv
module lrelu_dw_bank (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               s_valid,
    output logic                               s_ready,
    input  logic [lrelu_pkg::S_DATA_WIDTH-1:0] s_data,
    input  logic                               s_last,
    output logic                               m_valid,
    input  logic                               m_ready,
    output logic [lrelu_pkg::E_DATA_WIDTH-1:0] m_data,
    output logic                               m_last
);
    import lrelu_pkg::*;

    logic [S_DATA_WIDTH-1:0] beat_q;      // Held wide beat
    logic                    beat_last_q; // tlast of held beat
    logic                    full_q;
    logic [MEMBER_BITS-1:0]  member_q;    // Member currently on m_data
    logic                    final_member;
    logic                    s_hs;
    logic                    m_hs;

    assign final_member = (member_q == MEMBER_BITS'(MEMBERS-1));
    assign s_hs         = s_valid && s_ready;
    assign m_hs         = m_valid && m_ready;

    assign s_ready = !full_q;             // Registered, refill one cycle after drain
    assign m_valid = full_q;
    assign m_data  = beat_q[member_q*E_DATA_WIDTH +: E_DATA_WIDTH];  // Low member first
    assign m_last  = beat_last_q && final_member;

    // Occupancy and member index
    always_ff @(posedge aclk) begin
        if (reset) begin
            full_q   <= 1'b0;
            member_q <= '0;
        end else if (s_hs) begin
            full_q   <= 1'b1;
            member_q <= '0;
        end else if (m_hs) begin
            if (final_member) begin
                full_q   <= 1'b0;         // Buffer empty after last member
                member_q <= '0;
            end else begin
                member_q <= member_q + 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge aclk) begin
        if (s_hs) begin
            beat_q      <= s_data;
            beat_last_q <= s_last;
        end
    end

endmodule

// File: src/lrelu_engine.sv
module lrelu_engine (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               clken,      // All stages advance together
    input  logic                               s_valid,
    input  logic [lrelu_pkg::E_DATA_WIDTH-1:0] s_data,
    input  logic                               s_last,
    output logic                               m_valid,
    output logic [lrelu_pkg::M_DATA_WIDTH-1:0] m_data,
    output logic                               m_last,
    input  logic                               scale_we,
    input  logic                               bias_we,
    input  logic [lrelu_pkg::S_DATA_WIDTH-1:0] config_data,
    input  logic                               commit      // Token at stage 1 input
);
    import lrelu_pkg::*;

    logic        [SCALE_WIDTH-1:0]    scale_shadow [UNITS];
    logic        [SCALE_WIDTH-1:0]    scale_active [UNITS];
    logic signed [BIAS_WIDTH-1:0]     bias_shadow  [UNITS];
    logic signed [BIAS_WIDTH-1:0]     bias_active  [UNITS];

    logic        [ENGINE_LATENCY-1:0] valid_q;
    logic        [ENGINE_LATENCY-1:0] last_q;
    logic                             commit_q;   // Token at stage 2 input

    logic signed [PROD_WIDTH-1:0]     s1_d [UNITS];
    logic signed [PROD_WIDTH-1:0]     s1_q [UNITS];
    logic signed [SUM_WIDTH-1:0]      s2_d [UNITS];
    logic signed [SUM_WIDTH-1:0]      s2_q [UNITS];
    logic signed [SUM_WIDTH-1:0]      leak [UNITS];
    logic signed [WORD_WIDTH_OUT-1:0] s3_d [UNITS];
    logic signed [WORD_WIDTH_OUT-1:0] s3_q [UNITS];

    // Shadow registers take the next iteration's config
    always_ff @(posedge aclk) begin
        for (int u = 0; u < UNITS; u++) begin
            if (scale_we)
                scale_shadow[u] <= config_data[u*SCALE_WIDTH +: SCALE_WIDTH];
            if (bias_we)
                bias_shadow[u]  <= config_data[u*BIAS_WIDTH +: BIAS_WIDTH];
        end
    end

    // Active registers follow the token, one stage apart
    always_ff @(posedge aclk) begin
        if (clken && commit)
            scale_active <= scale_shadow;
        if (clken && commit_q)
            bias_active  <= bias_shadow;
    end

    always_comb begin
        for (int u = 0; u < UNITS; u++) begin
            // Stage 1 multiply by scale, requantize
            s1_d[u] = ($signed(s_data[u*WORD_WIDTH_IN +: WORD_WIDTH_IN])
                       * $signed({1'b0, scale_active[u]})) >>> REQ_SHIFT;
            // Stage 2 bias
            s2_d[u] = s1_q[u] + bias_active[u];
            // Stage 3 leak on negatives, then clip
            leak[u] = s2_q[u][SUM_WIDTH-1] ? (s2_q[u] >>> LEAK_SHIFT) : s2_q[u];
            if (leak[u] > OUT_MAX)
                s3_d[u] = WORD_WIDTH_OUT'(OUT_MAX);
            else if (leak[u] < OUT_MIN)
                s3_d[u] = WORD_WIDTH_OUT'(OUT_MIN);
            else
                s3_d[u] = leak[u][WORD_WIDTH_OUT-1:0];
        end
    end

    // Data stages and last, frozen while clken is low
    always_ff @(posedge aclk) begin
        if (clken) begin
            s1_q   <= s1_d;
            s2_q   <= s2_d;
            s3_q   <= s3_d;
            last_q <= {last_q[ENGINE_LATENCY-2:0], s_last};
        end
    end

    // Valid and token
    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q  <= '0;
            commit_q <= 1'b0;
        end else if (clken) begin
            valid_q  <= {valid_q[ENGINE_LATENCY-2:0], s_valid};
            commit_q <= commit;
        end
    end

    assign m_valid = valid_q[ENGINE_LATENCY-1];
    assign m_last  = last_q[ENGINE_LATENCY-1];

    always_comb begin
        for (int u = 0; u < UNITS; u++)
            m_data[u*WORD_WIDTH_OUT +: WORD_WIDTH_OUT] = s3_q[u];
    end

endmodule

// File: src/lrelu_pkg.sv
package lrelu_pkg;

    // Stream geometry
    localparam int UNITS          = 4;   // Lanes per member
    localparam int MEMBERS        = 2;   // Members per wide slave beat
    localparam int MEMBER_BITS    = (MEMBERS > 1) ? $clog2(MEMBERS) : 1;

    // Word widths
    localparam int WORD_WIDTH_IN  = 16;  // Signed accumulator word
    localparam int WORD_WIDTH_OUT = 8;   // Signed output word
    localparam int SCALE_WIDTH    = 8;   // Unsigned per-lane scale
    localparam int BIAS_WIDTH     = 16;  // Signed per-lane bias

    // Requantize and leak
    localparam int REQ_SHIFT      = 6;
    localparam int LEAK_SHIFT     = 3;

    // Scale is zero extended by one bit before the signed multiply
    localparam int PROD_WIDTH     = WORD_WIDTH_IN + SCALE_WIDTH + 1;
    localparam int SUM_WIDTH      = PROD_WIDTH + 1;     // Room for the bias add
    localparam int OUT_MAX        = 2**(WORD_WIDTH_OUT-1) - 1;
    localparam int OUT_MIN        = -(2**(WORD_WIDTH_OUT-1));

    // Bus widths
    localparam int S_DATA_WIDTH   = MEMBERS * UNITS * WORD_WIDTH_IN;  // 128
    localparam int E_DATA_WIDTH   = UNITS * WORD_WIDTH_IN;            // 64
    localparam int M_DATA_WIDTH   = UNITS * WORD_WIDTH_OUT;           // 32

    localparam int ENGINE_LATENCY = 3;   // Multiply/shift, bias, leak/clip

    // Iteration controller
    typedef enum logic [2:0] {
        PASS_S,         // Slave port feeds the width converter
        DRAIN_S,        // Wait for last member to leave converter
        WRITE_SCALE_S,  // First config beat
        WRITE_BIAS_S,   // Second config beat
        COMMIT_S        // Token into engine pipeline
    } config_state_t;

endpackage

// File: tb/tb_axis_lrelu_engine.sv
module tb_axis_lrelu_engine;
    timeunit 1ns;
    timeprecision 1ps;

    import lrelu_pkg::*;

    localparam int     ITERATIONS  = 40;
    localparam int     MAX_BEATS   = 10;     // Two config beats and up to eight data beats
    localparam int     CLK_PERIOD  = 40;
    localparam longint WATCHDOG_NS = longint'(ITERATIONS) * MAX_BEATS * MEMBERS * 20 * CLK_PERIOD;

    logic                    aclk = 1'b0;
    logic                    reset;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic [S_DATA_WIDTH-1:0] s_axis_tdata;
    logic                    s_axis_tlast;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;
    logic [M_DATA_WIDTH-1:0] m_axis_tdata;
    logic                    m_axis_tlast;

    logic [M_DATA_WIDTH-1:0] exp_data [$];   // Model output in order
    logic                    exp_last [$];
    int                      iter_len [$];   // Outputs per iteration
    int    error_count  = 0;
    int    iter_errors  = 0;
    int    reset_errors = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    out_count    = 0;
    int    out_iter     = 0;
    int    seed_init;
    logic                    hold_valid;     // Stalled output seen on previous cycle
    logic [M_DATA_WIDTH-1:0] hold_data;
    logic                    hold_last;

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    axis_lrelu_engine DUT (.*);

    // Requantize, leak and clip one lane
    function automatic logic [WORD_WIDTH_OUT-1:0] lane_result(
        input logic signed [WORD_WIDTH_IN-1:0] acc,
        input logic        [SCALE_WIDTH-1:0]   scale,
        input logic signed [BIAS_WIDTH-1:0]    bias
    );
        int v;
        v = int'(acc) * int'({1'b0, scale});
        v = (v >>> REQ_SHIFT) + int'(bias);
        if (v < 0)
            v = v >>> LEAK_SHIFT;                      // Leaky slope for negatives
        if (v > OUT_MAX)
            v = OUT_MAX;
        else if (v < OUT_MIN)
            v = OUT_MIN;
        return v[WORD_WIDTH_OUT-1:0];
    endfunction

    function automatic logic [S_DATA_WIDTH-1:0] random_wide();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Clip limits and leak for member 0 lanes then member 1 lanes
    function automatic logic [WORD_WIDTH_IN-1:0] directed_acc(input int idx);
        case (idx)
            0, 2:    return 16'h7fff;
            1, 3:    return 16'h8000;
            4:       return 16'h0000;
            5:       return 16'hffd8;               // -40 lands inside the leak range
            6:       return 16'h0040;
            default: return 16'hff00;
        endcase
    endfunction

    function automatic int gap_cycles(input bit back_to_back);
        if (back_to_back || $urandom_range(0, 3) != 0)
            return 0;
        return $urandom_range(1, 3);
    endfunction

    // Present one beat at the falling edge and hold it until taken
    task automatic send_beat(input logic [S_DATA_WIDTH-1:0] data, input logic last,
                             input int gap);
        logic taken;
        s_axis_tvalid = 1'b0;
        repeat (gap) @(negedge aclk);
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = data;
        s_axis_tlast  = last;
        taken = 1'b0;
        while (!taken) begin
            taken = s_axis_tready;                     // Registered so stable up to the rising edge
            @(negedge aclk);
        end
        s_axis_tvalid = 1'b0;
    endtask

    task automatic run_iteration(input int idx);
        logic        [S_DATA_WIDTH-1:0]   beat;
        logic        [SCALE_WIDTH-1:0]    scale [UNITS];
        logic signed [BIAS_WIDTH-1:0]     bias  [UNITS];
        logic signed [WORD_WIDTH_IN-1:0]  acc;
        logic        [M_DATA_WIDTH-1:0]   word;
        int                               n_beats;
        bit                               back_to_back;
        back_to_back = (idx % 4 == 3);                 // Every fourth iteration without gaps
        n_beats      = $urandom_range(1, 8);
        beat = random_wide();                          // Bits above the lanes are noise
        for (int u = 0; u < UNITS; u++) begin
            scale[u] = $urandom_range(0, 255);
            if (idx == 0)
                scale[u] = (u < 2) ? 8'd64 : ((u == 2) ? 8'd255 : 8'd1);
            beat[u*SCALE_WIDTH +: SCALE_WIDTH] = scale[u];
        end
        send_beat(beat, 1'($urandom_range(0, 1)), gap_cycles(back_to_back));
        beat = random_wide();
        for (int u = 0; u < UNITS; u++) begin
            if (idx == 0 || $urandom_range(0, 4) == 0)
                bias[u] = '0;
            else
                bias[u] = $urandom_range(0, 2047) - 1024;
            beat[u*BIAS_WIDTH +: BIAS_WIDTH] = bias[u];
        end
        send_beat(beat, 1'($urandom_range(0, 1)), gap_cycles(back_to_back));
        iter_len.push_back(MEMBERS * n_beats);
        for (int b = 0; b < n_beats; b++) begin
            for (int m = 0; m < MEMBERS; m++) begin
                for (int u = 0; u < UNITS; u++) begin
                    if (idx == 0 && b == 0)
                        acc = directed_acc(m * UNITS + u);
                    else if ($urandom_range(0, 3) == 0)
                        acc = $urandom;                // Full range and mostly clipped
                    else
                        acc = $urandom_range(0, 1023) - 512;
                    beat[(m*UNITS+u)*WORD_WIDTH_IN +: WORD_WIDTH_IN] = acc;
                    word[u*WORD_WIDTH_OUT +: WORD_WIDTH_OUT] = lane_result(acc, scale[u], bias[u]);
                end
                exp_data.push_back(word);
                exp_last.push_back(b == n_beats - 1 && m == MEMBERS - 1);
            end
            send_beat(beat, b == n_beats - 1, gap_cycles(back_to_back));
        end
    endtask

    task automatic score_output();
        logic [M_DATA_WIDTH-1:0] want_data;
        logic                    want_last;
        int                      want_len;
        assert (exp_data.size() != 0) else begin
            $display("Output appeared with no expected word left");
            iter_errors++;
        end
        if (exp_data.size() != 0) begin
            want_data = exp_data.pop_front();
            want_last = exp_last.pop_front();
            assert (m_axis_tdata === want_data) else begin
                $display("Error m_axis_tdata expected %h got %h", want_data, m_axis_tdata);
                iter_errors++;
            end
            assert (m_axis_tlast === want_last) else begin
                $display("Error m_axis_tlast expected %h got %h", want_last, m_axis_tlast);
                iter_errors++;
            end
        end
        out_count++;
        if (m_axis_tlast === 1'b1) begin               // Iteration end as the DUT marks it
            want_len = (iter_len.size() != 0) ? iter_len.pop_front() : 0;
            assert (out_count == want_len) else begin
                $display("Iteration %0d gave %0d outputs instead of %0d",
                         out_iter, out_count, want_len);
                iter_errors++;
            end
            $display("iteration %0d: %0d outputs, %0d errors",
                     out_iter, out_count, iter_errors);
            tests_run++;
            if (iter_errors != 0)
                tests_failed++;
            error_count += iter_errors;
            iter_errors = 0;
            out_count   = 0;
            out_iter++;
        end
    endtask

    // Master side ready, stability and scoreboard on the falling edge
    always @(negedge aclk) begin
        m_axis_tready = ($urandom_range(0, 99) < 70);
        if (!reset) begin
            if (hold_valid) begin
                assert (m_axis_tvalid) else begin
                    $display("m_axis_tvalid dropped while the output was stalled");
                    iter_errors++;
                end
                assert (m_axis_tdata === hold_data) else begin
                    $display("Error m_axis_tdata expected %h got %h", hold_data, m_axis_tdata);
                    iter_errors++;
                end
                assert (m_axis_tlast === hold_last) else begin
                    $display("Error m_axis_tlast expected %h got %h", hold_last, m_axis_tlast);
                    iter_errors++;
                end
            end
            if (m_axis_tvalid && m_axis_tready)
                score_output();
            hold_valid = m_axis_tvalid && !m_axis_tready;
            hold_data  = m_axis_tdata;
            hold_last  = m_axis_tlast;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run hung, outputs still missing with the controller in %s",
                 DUT.ctrl.state.name());
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed_init     = $urandom(32'hb0d1);
        reset         = 1'b1;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        hold_valid    = 1'b0;
        repeat (8) begin
            @(negedge aclk);
            assert (m_axis_tvalid === 1'b0) else begin
                $display("Error m_axis_tvalid expected %h got %h", 1'b0, m_axis_tvalid);
                reset_errors++;
            end
        end
        reset = 1'b0;
        @(negedge aclk);                               // First cycle out of reset
        assert (m_axis_tvalid === 1'b0) else begin
            $display("Error m_axis_tvalid expected %h got %h", 1'b0, m_axis_tvalid);
            reset_errors++;
        end
        $display("reset: %0d errors", reset_errors);
        tests_run++;
        if (reset_errors != 0)
            tests_failed++;
        error_count += reset_errors;

        for (int i = 0; i < ITERATIONS; i++)
            run_iteration(i);

        while (exp_data.size() != 0)
            @(negedge aclk);
        repeat (20) @(negedge aclk);                   // Catch stray extra outputs
        error_count += iter_errors;
        assert (out_iter == ITERATIONS) else begin
            $display("Only %0d of %0d iterations ended with m_axis_tlast", out_iter, ITERATIONS);
            error_count++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
